// ==== hw/m5_cfg_pkg.sv ====
package m5_cfg_pkg;

    // Memory extension and cartridge selection from the menu
    typedef logic [4:0] ram_mode_t;

    // Menu status word as delivered by the board wrapper
    typedef struct packed {
        logic [13:0] spare_hi;
        logic        reset_req;
        logic        border;
        logic [10:0] spare_lo;
        ram_mode_t   ram_mode;
    } m5_status_t;

    // Enable divider width
    localparam int CE_DIV_W = 5;

    // clk_sys cycles per sound tick
    localparam int PSG_DIV = 32;

    // Console reset hold time after the last cause clears
    localparam int RESET_STRETCH = 16;

endpackage

// ==== hw/psg_pkg.sv ====
package psg_pkg;

    localparam int PSG_CHANNELS = 3;

    localparam int PERIOD_W = 10;
    localparam int ATTEN_W  = 4;
    localparam int AUDIO_W  = 11;

    // Attenuation value for a silent channel
    localparam logic [ATTEN_W-1:0] ATTEN_OFF = '1;

    // Register state of one tone channel
    typedef struct packed {
        logic [PERIOD_W-1:0] period;
        logic [ATTEN_W-1:0]  atten;
    } psg_chan_regs_t;

    // Output state of one tone channel
    typedef struct packed {
        logic               level;
        logic [ATTEN_W-1:0] atten;
    } psg_tone_t;

    // Amplitude per attenuation step, roughly 2 dB apart
    localparam logic [8:0] PSG_VOL_LUT [16] = '{
        9'd511, 9'd406, 9'd322, 9'd256,
        9'd203, 9'd162, 9'd128, 9'd102,
        9'd81,  9'd64,  9'd51,  9'd41,
        9'd32,  9'd26,  9'd20,  9'd0
    };

endpackage

// ==== hw/clk_en_gen.sv ====
`timescale 1ns/1ps

module clk_en_gen (
    input  logic clk_sys,
    input  logic rst_n_i,
    output logic ce_10m7_o,
    output logic ce_5m3_o,
    output logic psg_tick_o
);

    import m5_cfg_pkg::*;

    localparam logic [CE_DIV_W-1:0] DIV_LAST = CE_DIV_W'(PSG_DIV - 1);

    logic [CE_DIV_W-1:0] div_q;

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_q <= '0;
        end else if (div_q == DIV_LAST) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    // Registered decode, all enables share phase 0
    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ce_10m7_o  <= 1'b0;
            ce_5m3_o   <= 1'b0;
            psg_tick_o <= 1'b0;
        end else begin
            ce_10m7_o  <= (div_q[1:0] == 2'd0);
            ce_5m3_o   <= (div_q[2:0] == 3'd0);
            psg_tick_o <= (div_q == '0);
        end
    end

endmodule

// ==== hw/sys_reset_ctrl.sv ====
`timescale 1ns/1ps

module sys_reset_ctrl (
    input  logic                   clk_sys,
    input  logic                   rst_n_i,
    input  m5_cfg_pkg::m5_status_t status_i,
    output logic                   sys_rst_n_o
);

    import m5_cfg_pkg::*;

    localparam int STRETCH_W = $clog2(RESET_STRETCH);
    localparam logic [STRETCH_W-1:0] STRETCH_LOAD = STRETCH_W'(RESET_STRETCH - 1);

    ram_mode_t            prev_mode_q;
    logic                 prev_valid_q;
    logic                 mode_changed;
    logic                 cause;
    logic [STRETCH_W-1:0] stretch_q;

    // First sample after board reset is not a change
    assign mode_changed = prev_valid_q && (status_i.ram_mode != prev_mode_q);
    assign cause        = mode_changed || status_i.reset_req;

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_mode_q  <= '0;
            prev_valid_q <= 1'b0;
        end else begin
            prev_mode_q  <= status_i.ram_mode;
            prev_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stretch_q   <= STRETCH_LOAD;
            sys_rst_n_o <= 1'b0;
        end else if (cause) begin
            stretch_q   <= STRETCH_LOAD;
            sys_rst_n_o <= 1'b0;
        end else begin
            if (stretch_q != '0) begin
                stretch_q <= stretch_q - 1'b1;
            end
            sys_rst_n_o <= (stretch_q == '0);
        end
    end

    // Console reset is held for the full stretch after every cause
    a_stretch: assert property (
        @(posedge clk_sys) disable iff (!rst_n_i)
        cause |=> !sys_rst_n_o [*RESET_STRETCH]
    ) else $error("console reset released early");

endmodule

// ==== hw/psg_reg_decoder.sv ====
`timescale 1ns/1ps

module psg_reg_decoder (
    input  logic                    clk_sys,
    input  logic                    rst_n_i,
    input  logic                    sys_rst_n_i,
    input  logic                    wr_i,
    input  logic [7:0]              data_i,
    output psg_pkg::psg_chan_regs_t regs_o [psg_pkg::PSG_CHANNELS]
);

    import psg_pkg::*;

    logic [1:0] last_ch_q;
    logic       last_tone_q;
    logic       latch_byte;
    logic [1:0] wr_ch;
    logic       regs_silent;

    assign latch_byte = data_i[7];
    assign wr_ch      = latch_byte ? data_i[6:5] : last_ch_q;

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_ch_q   <= '0;
            last_tone_q <= 1'b0;
            for (int i = 0; i < PSG_CHANNELS; i++) begin
                regs_o[i].period <= '0;
                regs_o[i].atten  <= ATTEN_OFF;
            end
        end else if (!sys_rst_n_i) begin
            last_ch_q   <= '0;
            last_tone_q <= 1'b0;
            for (int i = 0; i < PSG_CHANNELS; i++) begin
                regs_o[i].period <= '0;
                regs_o[i].atten  <= ATTEN_OFF;
            end
        end else if (wr_i) begin
            if (latch_byte) begin
                last_ch_q   <= data_i[6:5];
                last_tone_q <= !data_i[4];
            end
            // Channel 3 is the noise channel, not present here
            if (int'(wr_ch) < PSG_CHANNELS) begin
                if (latch_byte && data_i[4]) begin
                    regs_o[wr_ch].atten <= data_i[3:0];
                end else if (latch_byte) begin
                    regs_o[wr_ch].period[3:0] <= data_i[3:0];
                end else if (last_tone_q) begin
                    regs_o[wr_ch].period[9:4] <= data_i[5:0];
                end
            end
        end
    end

    always_comb begin
        regs_silent = 1'b1;
        for (int i = 0; i < PSG_CHANNELS; i++) begin
            if (regs_o[i].atten != ATTEN_OFF || regs_o[i].period != '0) begin
                regs_silent = 1'b0;
            end
        end
    end

    // Silent registers leave that state only through a write out of console reset
    a_no_wr_in_reset: assert property (
        @(posedge clk_sys) disable iff (!rst_n_i)
        regs_silent && !(wr_i && sys_rst_n_i) |=> regs_silent
    ) else $error("register write taken during console reset");

endmodule

// ==== hw/psg_tone_channel.sv ====
`timescale 1ns/1ps

module psg_tone_channel (
    input  logic                    clk_sys,
    input  logic                    rst_n_i,
    input  logic                    sys_rst_n_i,
    input  logic                    tick_i,
    input  psg_pkg::psg_chan_regs_t regs_i,
    output psg_pkg::psg_tone_t      tone_o
);

    import psg_pkg::*;

    logic [PERIOD_W-1:0] cnt_q;
    logic [PERIOD_W-1:0] reload;
    logic                level_q;

    // Period 0 behaves like period 1
    assign reload = (regs_i.period == '0) ? PERIOD_W'(1) : regs_i.period;

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q   <= '0;
            level_q <= 1'b0;
        end else if (!sys_rst_n_i) begin
            cnt_q   <= '0;
            level_q <= 1'b0;
        end else if (tick_i) begin
            if (cnt_q <= PERIOD_W'(1)) begin
                cnt_q   <= reload;
                level_q <= !level_q;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    assign tone_o = '{level: level_q, atten: regs_i.atten};

    // Each tick steps the countdown only once
    a_tick_pulse: assert property (
        @(posedge clk_sys) disable iff (!rst_n_i)
        tick_i |=> !tick_i
    ) else $error("sound tick held for more than one cycle");

endmodule

// ==== hw/psg_mixer.sv ====
`timescale 1ns/1ps

module psg_mixer (
    input  logic                       clk_sys,
    input  logic                       rst_n_i,
    input  psg_pkg::psg_tone_t         tones_i [psg_pkg::PSG_CHANNELS],
    output logic [psg_pkg::AUDIO_W-1:0] audio_o
);

    import psg_pkg::*;

    // One spare bit to catch an overflowing sum
    logic [AUDIO_W:0] sum;

    always_comb begin
        sum = '0;
        for (int i = 0; i < PSG_CHANNELS; i++) begin
            if (tones_i[i].level) begin
                sum = sum + (AUDIO_W + 1)'(PSG_VOL_LUT[tones_i[i].atten]);
            end
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            audio_o <= '0;
        end else begin
            audio_o <= sum[AUDIO_W-1:0];
        end
    end

    a_no_overflow: assert property (
        @(posedge clk_sys) disable iff (!rst_n_i)
        sum < (AUDIO_W + 1)'(2 ** AUDIO_W)
    ) else $error("audio sum overflows the output word");

endmodule

// ==== hw/m5_sound_top.sv ====
`timescale 1ns/1ps

module m5_sound_top (
    input  logic                        clk_sys,
    input  logic                        rst_n_i,
    input  m5_cfg_pkg::m5_status_t      status_i,
    input  logic                        psg_wr_i,
    input  logic [7:0]                  psg_data_i,
    output logic                        ce_10m7_o,
    output logic                        ce_5m3_o,
    output logic                        sys_rst_n_o,
    output logic [psg_pkg::AUDIO_W-1:0] audio_o
);

    import psg_pkg::*;

    logic           psg_tick;
    psg_chan_regs_t chan_regs [PSG_CHANNELS];
    psg_tone_t      tones     [PSG_CHANNELS];

    clk_en_gen i_clk_en_gen (
        .clk_sys    (clk_sys),
        .rst_n_i    (rst_n_i),
        .ce_10m7_o  (ce_10m7_o),
        .ce_5m3_o   (ce_5m3_o),
        .psg_tick_o (psg_tick)
    );

    sys_reset_ctrl i_sys_reset_ctrl (
        .clk_sys     (clk_sys),
        .rst_n_i     (rst_n_i),
        .status_i    (status_i),
        .sys_rst_n_o (sys_rst_n_o)
    );

    // CPU side is reduced to a byte write strobe
    psg_reg_decoder i_psg_reg_decoder (
        .clk_sys     (clk_sys),
        .rst_n_i     (rst_n_i),
        .sys_rst_n_i (sys_rst_n_o),
        .wr_i        (psg_wr_i),
        .data_i      (psg_data_i),
        .regs_o      (chan_regs)
    );

    for (genvar i = 0; i < PSG_CHANNELS; i++) begin : g_chan
        psg_tone_channel i_psg_tone_channel (
            .clk_sys     (clk_sys),
            .rst_n_i     (rst_n_i),
            .sys_rst_n_i (sys_rst_n_o),
            .tick_i      (psg_tick),
            .regs_i      (chan_regs[i]),
            .tone_o      (tones[i])
        );
    end

    psg_mixer i_psg_mixer (
        .clk_sys (clk_sys),
        .rst_n_i (rst_n_i),
        .tones_i (tones),
        .audio_o (audio_o)
    );

endmodule

// ==== verification/tb_m5_sound.sv ====
`timescale 1ns/1ps

module tb_m5_sound;

    import m5_cfg_pkg::*;
    import psg_pkg::*;

    localparam int CLK_HALF        = 20;
    localparam int RAND_PERIOD_MAX = 127;
    localparam int EDGE_LIMIT      = 2 * (RAND_PERIOD_MAX + 1) * PSG_DIV;
    localparam int MONITOR_CYCLES  = 3000;
    localparam int SILENCE_CYCLES  = 400;
    // Worst case of all tests summed, then doubled
    localparam int WATCHDOG_CYCLES = 2 * (SILENCE_CYCLES * 3 + 200 + 7 * 3 * PSG_DIV
        + MONITOR_CYCLES + 5 * RAND_PERIOD_MAX * PSG_DIV + 15 * 18 * PSG_DIV);
    localparam logic [31:0] LFSR_SEED = 32'h97f0e265;

    logic               clk_sys;
    logic               rst_n_i;
    m5_status_t         status;
    logic               psg_wr;
    logic [7:0]         psg_data;
    logic               ce_10m7;
    logic               ce_5m3;
    logic               sys_rst_n;
    logic [AUDIO_W-1:0] audio;

    logic [31:0] lfsr_q;
    int          test_errs;
    int          tests_passed;
    int          tests_failed;

    m5_sound_top i_m5_sound_top (
        .clk_sys     (clk_sys),
        .rst_n_i     (rst_n_i),
        .status_i    (status),
        .psg_wr_i    (psg_wr),
        .psg_data_i  (psg_data),
        .ce_10m7_o   (ce_10m7),
        .ce_5m3_o    (ce_5m3),
        .sys_rst_n_o (sys_rst_n),
        .audio_o     (audio)
    );

    initial begin
        clk_sys = 1'b0;
        forever #CLK_HALF clk_sys = ~clk_sys;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("Watchdog expired after %0d cycles, simulation stopped", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic bit is_subset_sum(input int v, input int a0, input int a1, input int a2);
        int s;
        for (int m = 0; m < 8; m++) begin
            s = (m[0] ? a0 : 0) + (m[1] ? a1 : 0) + (m[2] ? a2 : 0);
            if (v == s) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic write_byte(input logic [7:0] b);
        psg_data = b;
        psg_wr   = 1'b1;
        @(negedge clk_sys);
        psg_wr   = 1'b0;
        psg_data = 8'h00;
    endtask

    task automatic write_atten(input logic [1:0] ch, input logic [3:0] a);
        write_byte({1'b1, ch, 1'b1, a});
    endtask

    // Latch byte with the low nibble, then data byte with the high bits
    task automatic write_period(input logic [1:0] ch, input logic [9:0] p);
        write_byte({1'b1, ch, 1'b0, p[3:0]});
        write_byte({2'b00, p[9:4]});
    endtask

    // Cycles until audio_o leaves its current value, -1 on timeout
    task automatic wait_edge(output int cycles, input string tname);
        int start;
        start  = int'(audio);
        cycles = 0;
        while (int'(audio) == start && cycles < EDGE_LIMIT) begin
            @(negedge clk_sys);
            cycles++;
        end
        if (int'(audio) == start) begin
            $display("%s: audio_o did not change within %0d cycles", tname, EDGE_LIMIT);
            test_errs++;
            cycles = -1;
        end
    endtask

    task automatic check_tone(input int level_cycles, input int amp, input int nlevels,
                              input string tname);
        int len;
        int v;
        repeat (2) @(negedge clk_sys);
        // First level is partial, the next may still run on the old period
        wait_edge(len, tname);
        wait_edge(len, tname);
        for (int i = 0; i < nlevels && len >= 0; i++) begin
            v = int'(audio);
            wait_edge(len, tname);
            if (v != 0 && v != amp) begin
                $display("MISMATCH @ %0t: %s level value %0d, expected 0 or %0d",
                         $time, tname, v, amp);
                test_errs++;
            end
            if (len >= 0 && len != level_cycles) begin
                $display("MISMATCH @ %0t: %s level lasted %0d cycles, expected %0d",
                         $time, tname, len, level_cycles);
                test_errs++;
            end
        end
    endtask

    task automatic check_silence(input int n, input string tname);
        for (int i = 0; i < n; i++) begin
            @(negedge clk_sys);
            if (audio != '0) begin
                $display("MISMATCH @ %0t: %s audio_o is %0d, expected silence",
                         $time, tname, audio);
                test_errs++;
                break;
            end
        end
    endtask

    task automatic check_reset_hold(input string cause_name);
        int low;
        low = 0;
        while (!sys_rst_n && low < 8 * RESET_STRETCH) begin
            low++;
            @(negedge clk_sys);
        end
        if (low == 0) begin
            $display("reset_causes: console reset not asserted after %s", cause_name);
            test_errs++;
        end else if (!sys_rst_n) begin
            $display("reset_causes: console reset stuck low after %s", cause_name);
            test_errs++;
        end else if (low < RESET_STRETCH) begin
            $display("MISMATCH @ %0t: reset after %s held %0d cycles, expected at least %0d",
                     $time, cause_name, low, RESET_STRETCH);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string tname);
        if (test_errs == 0) begin
            tests_passed++;
            $display("%s: passed", tname);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", tname, test_errs);
        end
    endtask

    task automatic test_reset_idle();
        int n;
        int last_fast;
        int last_slow;
        int fast_cnt;
        int slow_cnt;
        test_errs = 0;
        n = 0;
        while (!sys_rst_n && n < 4 * RESET_STRETCH) begin
            @(negedge clk_sys);
            n++;
        end
        if (!sys_rst_n) begin
            $display("reset_idle: console reset never released");
            test_errs++;
        end
        check_silence(SILENCE_CYCLES, "reset_idle");
        last_fast = -1;
        last_slow = -1;
        fast_cnt  = 0;
        slow_cnt  = 0;
        for (int i = 0; i < 64; i++) begin
            @(negedge clk_sys);
            if (ce_10m7) begin
                if (last_fast >= 0 && i - last_fast != 4) begin
                    $display("MISMATCH @ %0t: ce_10m7_o spacing %0d, expected 4",
                             $time, i - last_fast);
                    test_errs++;
                end
                last_fast = i;
                fast_cnt++;
            end
            if (ce_5m3) begin
                if (last_slow >= 0 && i - last_slow != 8) begin
                    $display("MISMATCH @ %0t: ce_5m3_o spacing %0d, expected 8",
                             $time, i - last_slow);
                    test_errs++;
                end
                last_slow = i;
                slow_cnt++;
            end
        end
        if (fast_cnt != 16 || slow_cnt != 8) begin
            $display("MISMATCH @ %0t: enable pulses %0d and %0d in 64 cycles, expected 16 and 8",
                     $time, fast_cnt, slow_cnt);
            test_errs++;
        end
        finish_test("reset_idle");
    endtask

    task automatic test_single_tone();
        test_errs = 0;
        write_atten(2'd0, 4'd0);
        write_period(2'd0, 10'd3);
        check_tone(3 * PSG_DIV, int'(PSG_VOL_LUT[0]), 4, "single_tone");
        finish_test("single_tone");
    endtask

    task automatic test_random_tones();
        int per [PSG_CHANNELS];
        int att [PSG_CHANNELS];
        int v;
        test_errs = 0;
        for (int ch = 0; ch < PSG_CHANNELS; ch++) begin
            take_bits(7, per[ch]);
            // Channel 0 stays audible for the duration check
            take_bits(ch == 0 ? 3 : 4, att[ch]);
            write_period(2'(ch), 10'(per[ch]));
            write_atten(2'(ch), 4'(att[ch]));
        end
        repeat (2) @(negedge clk_sys);
        for (int i = 0; i < MONITOR_CYCLES; i++) begin
            v = int'(audio);
            if (!is_subset_sum(v, int'(PSG_VOL_LUT[att[0]]), int'(PSG_VOL_LUT[att[1]]),
                               int'(PSG_VOL_LUT[att[2]]))) begin
                $display("MISMATCH @ %0t: random_tones audio_o %0d is no sum of channel amplitudes",
                         $time, v);
                test_errs++;
                break;
            end
            @(negedge clk_sys);
        end
        write_atten(2'd1, 4'hf);
        write_atten(2'd2, 4'hf);
        check_tone(((per[0] == 0) ? 1 : per[0]) * PSG_DIV, int'(PSG_VOL_LUT[att[0]]), 2,
                   "random_tones");
        finish_test("random_tones");
    endtask

    task automatic test_data_byte_rule();
        test_errs = 0;
        write_period(2'd0, 10'd2);
        // Data byte after an attenuation latch must be ignored
        write_atten(2'd0, 4'd0);
        write_byte(8'h01);
        check_tone(2 * PSG_DIV, int'(PSG_VOL_LUT[0]), 2, "data_byte_rule");
        write_byte(8'h82);
        write_byte(8'h01);
        check_tone(18 * PSG_DIV, int'(PSG_VOL_LUT[0]), 2, "data_byte_rule");
        // Noise channel writes
        write_byte(8'he5);
        write_byte(8'h03);
        write_byte(8'hf0);
        check_tone(18 * PSG_DIV, int'(PSG_VOL_LUT[0]), 2, "data_byte_rule");
        finish_test("data_byte_rule");
    endtask

    task automatic test_reset_causes();
        int len;
        test_errs = 0;
        status.ram_mode = 5'h03;
        @(negedge clk_sys);
        check_reset_hold("ram_mode change");
        check_silence(SILENCE_CYCLES, "reset_causes");
        write_atten(2'd0, 4'd0);
        write_period(2'd0, 10'd2);
        wait_edge(len, "reset_causes");
        status.reset_req = 1'b1;
        repeat (3) @(negedge clk_sys);
        status.reset_req = 1'b0;
        check_reset_hold("reset_req");
        check_silence(SILENCE_CYCLES, "reset_causes");
        finish_test("reset_causes");
    endtask

    initial begin
        rst_n_i      = 1'b0;
        status       = '0;
        psg_wr       = 1'b0;
        psg_data     = 8'h00;
        lfsr_q       = LFSR_SEED;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (10) @(negedge clk_sys);
        rst_n_i = 1'b1;

        test_reset_idle();
        test_single_tone();
        test_random_tones();
        test_data_byte_rule();
        test_reset_causes();

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/m5_cfg_pkg.sv
hw/psg_pkg.sv
hw/clk_en_gen.sv
hw/sys_reset_ctrl.sv
hw/psg_reg_decoder.sv
hw/psg_tone_channel.sv
hw/psg_mixer.sv
hw/m5_sound_top.sv
verification/tb_m5_sound.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the sound slice testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_m5_sound -f vlog.f -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_tb > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Test completed successfully" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi

exit 0
